// File: Makefile
# Verilator build and run for the game pixel generator testbench

VERILATOR ?= verilator
TOP       ?= tbGameTop
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUNFLAGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= Testbench failed

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BIN) $(RUNFLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdl/colorMixer.sv
`timescale 1ns/1ps

module colorMixer
(
    input  logic        Clk,
    input  logic        Reset,
    layerIf.sink        layers,
    output gamePkg::rgbT Pixel
);
    import gamePkg::*;

    rgbT mixColor;

    // priority: blank, player, pipe, hearts, sky
    always_comb
    begin
        if (!layers.Visible)
        begin
            mixColor = BlankColor;
        end
        else if (layers.PlayerOn)
        begin
            mixColor = PlayerColor;
        end
        else if (layers.PipeOn)
        begin
            mixColor = PipeColor;
        end
        else if (|layers.HeartOn)
        begin
            mixColor = HeartColor;
        end
        else
        begin
            mixColor = SkyColor;
        end
    end

    // ----------------------------------------------------------------------
    // pipeline stage two
    // ----------------------------------------------------------------------

    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
        begin
            Pixel <= BlankColor;
        end
        else
        begin
            Pixel <= mixColor;
        end
    end

endmodule

// File: hdl/gamePkg.sv
package gamePkg;

    // ----------------------------------------------------------------------
    // basic types
    // ----------------------------------------------------------------------

    typedef logic [9:0] coordT;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgbT;

    typedef logic [26:0] scoreT;

    // lives machine, hit states last until the pipe is cleared
    typedef enum logic [2:0] {
        FullLives = 3'd0,
        HitFirst  = 3'd1,
        TwoLives  = 3'd2,
        HitSecond = 3'd3,
        OneLife   = 3'd4,
        NoLives   = 3'd5
    } lifeStateT;

    // ----------------------------------------------------------------------
    // screen geometry
    // ----------------------------------------------------------------------

    // pipe box
    localparam coordT PipeX = 10'd300;
    localparam coordT PipeY = 10'd380;
    localparam coordT PipeW = 10'd50;
    localparam coordT PipeH = 10'd100;

    // heart k starts at HeartX0 + k * HeartStep
    localparam coordT HeartX0   = 10'd450;
    localparam coordT HeartStep = 10'd50;
    localparam coordT HeartY    = 10'd20;
    localparam coordT HeartSize = 10'd50;

    // collision probe, measured from the player corner
    localparam coordT ProbeOffset = 10'd30;

    // ----------------------------------------------------------------------
    // palette
    // ----------------------------------------------------------------------

    localparam rgbT SkyColor    = 24'h0000FF;
    localparam rgbT PlayerColor = 24'h00FF44;
    localparam rgbT PipeColor   = 24'hCC7711;
    localparam rgbT HeartColor  = 24'hDD00FF;
    localparam rgbT BlankColor  = 24'h000000;

endpackage

// File: hdl/gameTop.sv
`timescale 1ns/1ps

module gameTop
#(
    parameter int TickCycles = 1048576
)
(
    input  logic           Clk,
    input  logic           Reset,
    input  gamePkg::coordT PlayerX,
    input  gamePkg::coordT PlayerY,
    input  gamePkg::coordT PlayerSize,
    input  gamePkg::coordT DrawX,
    input  gamePkg::coordT DrawY,
    input  logic           Blank,
    output logic [7:0]     Red,
    output logic [7:0]     Green,
    output logic [7:0]     Blue,
    output gamePkg::scoreT Score
);
    import gamePkg::*;

    rgbT        pixel;
    logic [2:0] heartsIntact;

    layerIf layers ();

    // ----------------------------------------------------------------------
    // pixel pipeline
    // ----------------------------------------------------------------------

    layerDecoder i_layerDecoder
    (
        .Clk          (Clk),
        .Reset        (Reset),
        .PlayerX      (PlayerX),
        .PlayerY      (PlayerY),
        .PlayerSize   (PlayerSize),
        .DrawX        (DrawX),
        .DrawY        (DrawY),
        .Blank        (Blank),
        .HeartsIntact (heartsIntact),
        .layers       (layers.source)
    );

    colorMixer i_colorMixer
    (
        .Clk    (Clk),
        .Reset  (Reset),
        .layers (layers.sink),
        .Pixel  (pixel)
    );

    assign Red   = pixel.red;
    assign Green = pixel.green;
    assign Blue  = pixel.blue;

    // ----------------------------------------------------------------------
    // game state
    // ----------------------------------------------------------------------

    lifeTracker i_lifeTracker
    (
        .Clk          (Clk),
        .Reset        (Reset),
        .PlayerX      (PlayerX),
        .PlayerY      (PlayerY),
        .HeartsIntact (heartsIntact)
    );

    scoreCounter #(.TickCycles(TickCycles)) i_scoreCounter
    (
        .Clk   (Clk),
        .Reset (Reset),
        .Score (Score)
    );

endmodule

// File: hdl/layerDecoder.sv
`timescale 1ns/1ps

module layerDecoder
(
    input  logic          Clk,
    input  logic          Reset,
    input  gamePkg::coordT PlayerX,
    input  gamePkg::coordT PlayerY,
    input  gamePkg::coordT PlayerSize,
    input  gamePkg::coordT DrawX,
    input  gamePkg::coordT DrawY,
    input  logic          Blank,
    input  logic [2:0]    HeartsIntact,
    layerIf.source        layers
);
    import gamePkg::*;

    logic       playerHit;
    logic       pipeHit;
    logic [2:0] heartHit;

    // half-open box test, end sums kept at 11 bits
    function automatic logic inBox(input coordT px, input coordT py, input coordT x0,
                                   input coordT y0, input coordT w, input coordT h);
        logic [10:0] xEnd;
        logic [10:0] yEnd;
        xEnd = {1'b0, x0} + {1'b0, w};
        yEnd = {1'b0, y0} + {1'b0, h};
        return (px >= x0) && ({1'b0, px} < xEnd) && (py >= y0) && ({1'b0, py} < yEnd);
    endfunction

    always_comb
    begin
        playerHit = inBox(DrawX, DrawY, PlayerX, PlayerY, PlayerSize, PlayerSize);
        pipeHit   = inBox(DrawX, DrawY, PipeX, PipeY, PipeW, PipeH);
    end

    // one box per heart, masked by its life
    for (genvar k = 0; k < 3; k++)
    begin : genHeart
        localparam coordT HeartLeft = HeartX0 + coordT'(k) * HeartStep;

        assign heartHit[k] = HeartsIntact[k] &&
                             inBox(DrawX, DrawY, HeartLeft, HeartY, HeartSize, HeartSize);
    end

    // ----------------------------------------------------------------------
    // pipeline stage one
    // ----------------------------------------------------------------------

    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
        begin
            layers.PlayerOn <= 1'b0;
            layers.PipeOn   <= 1'b0;
            layers.HeartOn  <= 3'b000;
            layers.Visible  <= 1'b0;
        end
        else
        begin
            layers.PlayerOn <= playerHit;
            layers.PipeOn   <= pipeHit;
            layers.HeartOn  <= heartHit;
            layers.Visible  <= Blank;
        end
    end

endmodule

// File: hdl/layerIf.sv
`timescale 1ns/1ps

interface layerIf;

    // layer hits for the pixel in stage one
    logic       PlayerOn;
    logic       PipeOn;
    logic [2:0] HeartOn;

    // blank flag, aligned with the layer hits
    logic       Visible;

    modport source
    (
        output PlayerOn,
        output PipeOn,
        output HeartOn,
        output Visible
    );

    modport sink
    (
        input PlayerOn,
        input PipeOn,
        input HeartOn,
        input Visible
    );

endinterface

// File: hdl/lifeTracker.sv
`timescale 1ns/1ps

module lifeTracker
(
    input  logic          Clk,
    input  logic          Reset,
    input  gamePkg::coordT PlayerX,
    input  gamePkg::coordT PlayerY,
    output logic [2:0]    HeartsIntact
);
    import gamePkg::*;

    lifeStateT state;
    lifeStateT stateNext;

    logic [10:0] probeX;
    logic [10:0] probeY;
    logic        collide;
    logic        cleared;

    // probe point strictly inside the pipe on both axes
    assign probeX  = {1'b0, PlayerX} + {1'b0, ProbeOffset};
    assign probeY  = {1'b0, PlayerY} + {1'b0, ProbeOffset};
    assign collide = (probeX > {1'b0, PipeX}) && (probeX < {1'b0, PipeX} + {1'b0, PipeW}) &&
                     (probeY > {1'b0, PipeY}) && (probeY < {1'b0, PipeY} + {1'b0, PipeH});

    // player fully past the right edge of the pipe
    assign cleared = {1'b0, PlayerX} > ({1'b0, PipeX} + {1'b0, PipeW});

    // ----------------------------------------------------------------------
    // lives FSM
    // ----------------------------------------------------------------------

    always_comb
    begin
        stateNext = state;
        case (state)
            FullLives : if (collide) stateNext = HitFirst;
            HitFirst  : if (cleared) stateNext = TwoLives;
            TwoLives  : if (collide) stateNext = HitSecond;
            HitSecond : if (cleared) stateNext = OneLife;
            OneLife   : if (collide) stateNext = NoLives;
            NoLives   : stateNext = NoLives;
            default   : stateNext = FullLives;
        endcase
    end

    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
        begin
            state <= FullLives;
        end
        else
        begin
            state <= stateNext;
        end
    end

    // heart 0 goes first, heart 2 only at game over
    always_comb
    begin
        case (state)
            FullLives : HeartsIntact = 3'b111;
            HitFirst,
            TwoLives  : HeartsIntact = 3'b110;
            HitSecond,
            OneLife   : HeartsIntact = 3'b100;
            NoLives   : HeartsIntact = 3'b000;
            default   : HeartsIntact = 3'b111;
        endcase
    end

endmodule

// File: hdl/scoreCounter.sv
`timescale 1ns/1ps

module scoreCounter
#(
    parameter int TickCycles = 1048576
)
(
    input  logic           Clk,
    input  logic           Reset,
    output gamePkg::scoreT Score
);

    localparam int CountW = (TickCycles > 1) ? $clog2(TickCycles) : 1;

    logic [CountW-1:0] prescale;
    logic              tick;

    // last cycle of each prescaler period
    assign tick = (prescale == CountW'(TickCycles - 1));

    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
        begin
            prescale <= '0;
            Score    <= '0;
        end
        else if (tick)
        begin
            prescale <= '0;
            Score    <= Score + 1'b1;
        end
        else
        begin
            prescale <= prescale + 1'b1;
        end
    end

endmodule

// File: tb.f
hdl/gamePkg.sv
hdl/layerIf.sv
hdl/layerDecoder.sv
hdl/colorMixer.sv
hdl/lifeTracker.sv
hdl/scoreCounter.sv
hdl/gameTop.sv
testbench/lifeTracker_assertions.sv
testbench/tbGameTop.sv

// File: testbench/lifeTracker_assertions.sv
`timescale 1ns/1ps

module lifeTracker_assertions
(
    input logic               Clk,
    input logic               Reset,
    input gamePkg::lifeStateT state,
    input logic [2:0]         HeartsIntact
);
    import gamePkg::*;

    int failCount = 0;

    // game over is final
    noLivesHeld : assert property (@(posedge Clk) disable iff (Reset)
        state == NoLives |=> state == NoLives)
    else
    begin
        failCount++;
        $error("lives FSM left the game-over state");
    end

    // a lost heart never comes back
    heartsMonotonic : assert property (@(posedge Clk) disable iff (Reset)
        (~$past(HeartsIntact) & HeartsIntact) == 3'b000)
    else
    begin
        failCount++;
        $error("a lost heart was restored without a reset");
    end

    hitFirstEntry : assert property (@(posedge Clk) disable iff (Reset)
        $rose(state == HitFirst) |-> $past(state) == FullLives)
    else
    begin
        failCount++;
        $error("first hit state entered from a wrong state");
    end

    hitSecondEntry : assert property (@(posedge Clk) disable iff (Reset)
        $rose(state == HitSecond) |-> $past(state) == TwoLives)
    else
    begin
        failCount++;
        $error("second hit state entered from a wrong state");
    end

    // all hearts right after reset
    heartsAfterReset : assert property (@(posedge Clk)
        $fell(Reset) |-> HeartsIntact == 3'b111)
    else
    begin
        failCount++;
        $error("hearts not all intact after reset");
    end

endmodule

bind lifeTracker lifeTracker_assertions i_lifeTrackerChecks
(
    .Clk          (Clk),
    .Reset        (Reset),
    .state        (state),
    .HeartsIntact (HeartsIntact)
);

// File: testbench/tbGameTop.sv
`timescale 1ns/1ps

module tbGameTop;

    localparam int TickCycles   = 16;
    localparam int ClockPeriod  = 4;
    localparam int ResetCycles  = 10;
    localparam int RandomPixels = 400;

    // cycle budget of all tests
    localparam int TestCycles = ResetCycles + 10 + (RandomPixels + 8) + 20 + 20 + 30 + 70;
    localparam int WatchdogNs = ClockPeriod * (TestCycles + 200);

    // palette
    localparam logic [23:0] SkyRgb    = 24'h0000FF;
    localparam logic [23:0] PlayerRgb = 24'h00FF44;
    localparam logic [23:0] PipeRgb   = 24'hCC7711;
    localparam logic [23:0] HeartRgb  = 24'hDD00FF;

    // screen geometry
    localparam int PipeLeft   = 300;
    localparam int PipeRight  = 350;
    localparam int PipeTop    = 380;
    localparam int PipeBottom = 480;
    localparam int HeartLeft  = 450;
    localparam int HeartStep  = 50;
    localparam int HeartTop   = 20;
    localparam int HeartSize  = 50;
    localparam int Probe      = 30;

    logic        Clk;
    logic        Reset;
    logic [9:0]  PlayerX;
    logic [9:0]  PlayerY;
    logic [9:0]  PlayerSize;
    logic [9:0]  DrawX;
    logic [9:0]  DrawY;
    logic        Blank;
    logic [7:0]  Red;
    logic [7:0]  Green;
    logic [7:0]  Blue;
    logic [26:0] Score;

    int          cycles;
    int          testErrors;
    int          testsPassed;
    int          testsFailed;
    int          assertFails;
    int          lostHearts;
    bit          waitClear;
    logic [31:0] rngState;
    logic [23:0] pending[$];

    gameTop #(.TickCycles(TickCycles)) i_gameTop
    (
        .Clk        (Clk),
        .Reset      (Reset),
        .PlayerX    (PlayerX),
        .PlayerY    (PlayerY),
        .PlayerSize (PlayerSize),
        .DrawX      (DrawX),
        .DrawY      (DrawY),
        .Blank      (Blank),
        .Red        (Red),
        .Green      (Green),
        .Blue       (Blue),
        .Score      (Score)
    );

    initial
    begin
        Clk = 1'b0;
        forever
        begin
            #(ClockPeriod / 2) Clk = ~Clk;
        end
    end

    initial
    begin
        #(WatchdogNs);
        $display("watchdog expired after %0d ns, the tests did not complete", WatchdogNs);
        $display("Testbench failed");
        $finish;
    end

    // ----------------------------------------------------------------------
    // reference model
    // ----------------------------------------------------------------------

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic bit probeInside(input int px, input int py);
        return (px + Probe > PipeLeft) && (px + Probe < PipeRight) &&
               (py + Probe > PipeTop) && (py + Probe < PipeBottom);
    endfunction

    // blank, player, pipe, intact heart, sky
    function automatic logic [23:0] expectedPixel(input int x, input int y, input bit vis,
                                                  input int px, input int py, input int ps,
                                                  input int lost);
        if (!vis)
            return 24'h000000;
        if (x >= px && x < px + ps && y >= py && y < py + ps)
            return PlayerRgb;
        if (x >= PipeLeft && x < PipeRight && y >= PipeTop && y < PipeBottom)
            return PipeRgb;
        for (int k = 0; k < 3; k++)
        begin
            if (lost <= k && x >= HeartLeft + k * HeartStep &&
                x < HeartLeft + k * HeartStep + HeartSize &&
                y >= HeartTop && y < HeartTop + HeartSize)
                return HeartRgb;
        end
        return SkyRgb;
    endfunction

    always @(posedge Clk)
    begin
        if (!Reset)
            cycles++;
    end

    // inputs seen here reach RGB two edges on
    always @(negedge Clk)
    begin : pixelMonitor
        logic [23:0] expected;
        if (Reset !== 1'b0)
        begin
            pending.delete();
            lostHearts = 0;
            waitClear  = 1'b0;
        end
        else
        begin
            if (pending.size() == 2)
            begin
                expected = pending.pop_front();
                checkValue("RGB", expected, {Red, Green, Blue});
            end
            checkValue("Score", cycles / TickCycles, Score);
            pending.push_back(expectedPixel(int'(DrawX), int'(DrawY), Blank, int'(PlayerX),
                                            int'(PlayerY), int'(PlayerSize), lostHearts));
            if (!waitClear && lostHearts < 3 && probeInside(int'(PlayerX), int'(PlayerY)))
            begin
                lostHearts++;
                waitClear = (lostHearts < 3);
            end
            else if (waitClear && int'(PlayerX) > PipeRight)
            begin
                waitClear = 1'b0;
            end
        end
    end

    // ----------------------------------------------------------------------
    // stimulus and checks
    // ----------------------------------------------------------------------

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected)
        else
        begin
            $display("[FAIL] %s expected %h actual %h at %0t", name, expected, actual, $time);
            testErrors++;
        end
    endtask

    task automatic step(input int n);
        repeat (n)
        begin
            @(posedge Clk);
            #1;
        end
    endtask

    task automatic drawPixel(input int x, input int y, input logic vis);
        DrawX = 10'(x);
        DrawY = 10'(y);
        Blank = vis;
        step(1);
    endtask

    task automatic drawRandomPixel(input bit heartBand);
        int x;
        int y;
        rngState = xorshift(rngState);
        x = int'(rngState[25:16]) % 640;
        y = heartBand ? int'(rngState[8:0]) % 100 : int'(rngState[8:0]) % 480;
        drawPixel(x, y, rngState[31]);
    endtask

    task automatic movePlayer(input int x, input int y);
        PlayerX = 10'(x);
        PlayerY = 10'(y);
        step(2);
    endtask

    // visible pixel at a heart center with its result two edges later
    task automatic checkHeart(input int k, input logic [23:0] expected);
        drawPixel(HeartLeft + k * HeartStep + HeartSize / 2, HeartTop + HeartSize / 2, 1'b1);
        step(1);
        checkValue("RGB", expected, {Red, Green, Blue});
    endtask

    task automatic checkScore();
        checkValue("Score", cycles / TickCycles, Score);
    endtask

    task automatic reportTest(input string name);
        if (testErrors == 0)
        begin
            $display("test %s: ok", name);
            testsPassed++;
        end
        else
        begin
            $display("test %s: %0d errors", name, testErrors);
            testsFailed++;
        end
        testErrors = 0;
    endtask

    initial
    begin
        Reset      = 1'b1;
        PlayerX    = 10'd100;
        PlayerY    = 10'd100;
        PlayerSize = 10'd40;
        DrawX      = 10'd0;
        DrawY      = 10'd0;
        Blank      = 1'b0;
        cycles     = 0;
        testErrors = 0;
        rngState   = 32'd21727;
        repeat (ResetCycles) @(posedge Clk);
        #1 Reset = 1'b0;

        checkValue("RGB", 24'h000000, {Red, Green, Blue});
        checkValue("Score", 0, Score);
        for (int k = 0; k < 3; k++)
            checkHeart(k, HeartRgb);
        reportTest("reset state");

        // player overlaps the pipe but its probe stays outside
        PlayerX    = 10'd260;
        PlayerY    = 10'd350;
        PlayerSize = 10'd60;
        for (int i = 0; i < RandomPixels; i++)
            drawRandomPixel(i[0]);
        // overlap of player and pipe, then each box alone
        drawPixel(310, 390, 1'b1);
        drawPixel(310, 390, 1'b0);
        drawPixel(270, 360, 1'b1);
        drawPixel(330, 450, 1'b1);
        step(2);
        reportTest("layer priority");

        // probe at (320, 410)
        movePlayer(290, 380);
        checkHeart(0, SkyRgb);
        checkHeart(1, HeartRgb);
        checkHeart(2, HeartRgb);
        movePlayer(PipeRight, 380);
        movePlayer(290, 380);
        checkHeart(1, HeartRgb);
        reportTest("first life lost");

        movePlayer(300, 390);
        checkHeart(1, HeartRgb);
        movePlayer(360, 380);
        movePlayer(290, 380);
        checkHeart(1, SkyRgb);
        checkHeart(2, HeartRgb);
        reportTest("second hit");

        movePlayer(360, 380);
        movePlayer(290, 380);
        for (int k = 0; k < 3; k++)
            checkHeart(k, SkyRgb);
        movePlayer(360, 380);
        movePlayer(290, 380);
        for (int k = 0; k < 3; k++)
            checkHeart(k, SkyRgb);
        reportTest("game over");

        checkScore();
        step(37);
        checkScore();
        step(16);
        checkScore();
        step(5);
        checkScore();
        reportTest("score");

        assertFails = i_gameTop.i_lifeTracker.i_lifeTrackerChecks.failCount;
        $display("tests passed %0d, tests failed %0d, lives assertion failures %0d",
                 testsPassed, testsFailed, assertFails);
        if (testsFailed == 0 && assertFails == 0)
        begin
            $display("Testbench passed");
        end
        else
        begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
